/* sim.f */
+incdir+tb
verilog/g729Pkg.sv
verilog/scratchMem.sv
verilog/lMac.sv
verilog/convolve.sv
verilog/convolveTop.sv
tb/convolveTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = convolveTb
FILELIST = sim.f
OBJDIR = obj_dir
SIM = $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# Pass only when the pass line appears in the output
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "=== PASS ==="

clean:
	rm -rf $(OBJDIR)

/* tb/convolveRef.svh */
`ifndef CONVOLVE_REF_SVH
`define CONVOLVE_REF_SVH

////////////////////////////////////////////////////////////
// G.729 basic operators, 64-bit reference arithmetic
////////////////////////////////////////////////////////////

// L_mult, doubled product clipped to the positive limit
function automatic word32_t saturatingMult(input word16_t a, input word16_t b);
	longint product;
	product = 2 * (longint'(a) * longint'(b));
	if (product > longint'(MAX_32))
		return MAX_32;
	else
		return word32_t'(product);
endfunction

// L_add, exact sum clipped to both limits
function automatic word32_t clampedAdd(input word32_t a, input word32_t b);
	longint total;
	total = longint'(a) + longint'(b);
	if (total > longint'(MAX_32))
		return MAX_32;
	else if (total < longint'(MIN_32))
		return MIN_32;
	else
		return word32_t'(total);
endfunction

// y[n] = sum over i of x[i] * h[n-i], accumulated with L_mac
function automatic void modelConvolution(input word16_t x [L_SUB], input word16_t h [L_SUB],
	output word32_t y [L_SUB]);
	word32_t sum;
	for (int n = 0; n < L_SUB; n++)
	begin
		sum = '0;
		for (int k = 0; k <= n; k++)
			sum = clampedAdd(sum, saturatingMult(x[k], h[n-k]));
		y[n] = sum;
	end
endfunction

`endif

/* tb/convolveTb.sv */
module convolveTb;
	timeunit 1ns;
	timeprecision 1ps;

	import g729Pkg::*;

	`include "convolveRef.svh"

	// Worst-case cycles for one run
	localparam int PRODUCTS = L_SUB * (L_SUB + 1) / 2;
	localparam int RUN_CYCLES = 6 * PRODUCTS + 4 * L_SUB;
	// Host cycles to load x and h and read back all three regions
	localparam int HOST_CYCLES = 2 * 2 * L_SUB + 3 * 4 * L_SUB;
	localparam int NUM_RUNS = 5;
	localparam int WATCHDOG_CYCLES = NUM_RUNS * (RUN_CYCLES + HOST_CYCLES + 300);

	logic clk;
	logic reset;
	logic start;
	logic busy;
	logic done;
	logic [ADDR_W-1:0] hostAddr;
	logic hostWrite;
	memWord_t hostWriteData;
	memWord_t hostReadData;

	// Stimulus vectors and model output
	word16_t xVec [L_SUB];
	word16_t hVec [L_SUB];
	word32_t yModel [L_SUB];
	integer seed;
	int doneCount = 0;
	int runCount = 0;

	convolveTop convolveTop_i
	(
		.clk(clk),
		.reset(reset),
		.start(start),
		.busy(busy),
		.done(done),
		.hostAddr(hostAddr),
		.hostWrite(hostWrite),
		.hostWriteData(hostWriteData),
		.hostReadData(hostReadData)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Failure reporting
	////////////////////////////////////////////////////////////

	task automatic failWith(input string msg);
		$display("%s", msg);
		$display("=== FAIL ===");
		$fatal(1, "Simulation stopped at first failure");
	endtask

	task automatic reportMismatch(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		failWith($sformatf("[ERROR] %0d ns: %s got %h expected %h", $time, what, got,
			expected));
	endtask

	////////////////////////////////////////////////////////////
	// Host port access
	////////////////////////////////////////////////////////////

	task automatic writeWord(input logic [ADDR_W-1:0] addr, input memWord_t data);
		@(posedge clk);
		hostAddr <= addr;
		hostWrite <= 1'b1;
		hostWriteData <= data;
		@(posedge clk);
		hostWrite <= 1'b0;
	endtask

	// Data valid one cycle after the address
	// Sampled at the falling edge
	task automatic readWord(input logic [ADDR_W-1:0] addr, output memWord_t data);
		@(posedge clk);
		hostAddr <= addr;
		hostWrite <= 1'b0;
		@(posedge clk);
		@(negedge clk);
		data = hostReadData;
	endtask

	// Samples go in the low half
	// High half stays zero
	task automatic loadVectors();
		memWord_t word;
		word.full = '0;
		for (int k = 0; k < L_SUB; k++)
		begin
			word.half.lo = xVec[k];
			writeWord(X_BASE + ADDR_W'(k), word);
			word.half.lo = hVec[k];
			writeWord(H_BASE + ADDR_W'(k), word);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Run control and result checks
	////////////////////////////////////////////////////////////

	task automatic runConvolution(input bit extraStart);
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		@(negedge clk);
		assert (busy)
		else failWith("Busy did not rise after the start pulse");
		// Second pulse lands well inside the run
		if (extraStart)
		begin
			repeat (20) @(posedge clk);
			start <= 1'b1;
			@(posedge clk);
			start <= 1'b0;
		end
		// Wait for the done pulse
		do
			@(negedge clk);
		while (!done);
		runCount++;
		repeat (4) @(posedge clk);
	endtask

	task automatic checkRun(input string label);
		memWord_t word;
		modelConvolution(xVec, hVec, yModel);
		for (int k = 0; k < L_SUB; k++)
		begin
			readWord(Y_BASE + ADDR_W'(k), word);
			assert (word.full == yModel[k])
			else reportMismatch($sformatf("%s y[%0d]", label, k), word.full, yModel[k]);
		end
		// x and h regions untouched by the run
		for (int k = 0; k < L_SUB; k++)
		begin
			readWord(X_BASE + ADDR_W'(k), word);
			assert (word.full == {16'h0000, xVec[k]})
			else reportMismatch($sformatf("%s x[%0d]", label, k), word.full, {16'h0, xVec[k]});
			readWord(H_BASE + ADDR_W'(k), word);
			assert (word.full == {16'h0000, hVec[k]})
			else reportMismatch($sformatf("%s h[%0d]", label, k), word.full, {16'h0, hVec[k]});
		end
		assert (doneCount == runCount)
		else reportMismatch($sformatf("%s done pulse count", label), doneCount, runCount);
	endtask

	// One count per done pulse
	always @(negedge clk)
	begin
		if (!reset && done)
			doneCount <= doneCount + 1;
	end

	////////////////////////////////////////////////////////////
	// Done and busy protocol
	////////////////////////////////////////////////////////////

	doneOnePulse: assert property (@(posedge clk) disable iff (reset)
		done |-> !$past(done))
		else failWith($sformatf("[ERROR] %0d ns: done held high for two cycles", $time));

	// Busy falls in the same cycle as done
	busyDropsWithDone: assert property (@(posedge clk) disable iff (reset)
		done |-> (!busy && $past(busy)))
		else failWith($sformatf("[ERROR] %0d ns: busy not falling with done", $time));

	busyFallsOnlyAtDone: assert property (@(posedge clk) disable iff (reset)
		$fell(busy) |-> done)
		else failWith($sformatf("[ERROR] %0d ns: busy fell without done", $time));

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		memWord_t word;
		memWord_t expected;
		seed = 32'h6bbf;
		reset = 1'b1;
		start = 1'b0;
		hostAddr = '0;
		hostWrite = 1'b0;
		hostWriteData = '0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		assert (!busy && !done && !convolveTop_i.convWrite)
		else failWith("Busy, done or the convolve write strobe is active after reset");

		// Host round trip on spare words above the y region
		for (int k = 0; k < 8; k++)
		begin
			expected.full = $random(seed);
			writeWord(11'h400 + ADDR_W'(k * 37), expected);
			readWord(11'h400 + ADDR_W'(k * 37), word);
			assert (word.full == expected.full)
			else reportMismatch("host readback", word.full, expected.full);
		end

		// Small mixed-sign samples
		for (int k = 0; k < L_SUB; k++)
		begin
			xVec[k] = word16_t'((k % 5) * 250 - 500);
			hVec[k] = word16_t'(1200 - (k % 7) * 300);
		end
		loadVectors();
		runConvolution(1'b0);
		checkRun("small");

		// Both L_mult and L_add saturate
		for (int k = 0; k < L_SUB; k++)
		begin
			xVec[k] = 16'sh8000;
			hVec[k] = 16'sh8000;
		end
		loadVectors();
		runConvolution(1'b0);
		checkRun("saturate");
		for (int k = 0; k < L_SUB; k++)
		begin
			readWord(Y_BASE + ADDR_W'(k), word);
			assert (word.full == MAX_32)
			else reportMismatch($sformatf("saturate y[%0d]", k), word.full, MAX_32);
		end

		// Random runs
		// The first run gets a stray start
		for (int r = 0; r < 3; r++)
		begin
			for (int k = 0; k < L_SUB; k++)
			begin
				xVec[k] = word16_t'($random(seed));
				hVec[k] = word16_t'($random(seed));
			end
			loadVectors();
			runConvolution(r == 0);
			checkRun($sformatf("random%0d", r));
		end

		// No late done after the last run
		repeat (10) @(posedge clk);
		assert (doneCount == NUM_RUNS && !busy)
		else reportMismatch("final done pulse count", doneCount, NUM_RUNS);
		$display("=== PASS ===");
		$finish;
	end

	// Watchdog
	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		failWith($sformatf("Timeout: convolution runs did not finish within %0d cycles",
			WATCHDOG_CYCLES));
	end

endmodule

/* verilog/convolveTop.sv */
module convolveTop
(
	input logic clk,
	input logic reset,
	input logic start,
	output logic busy,
	output logic done,
	input logic [g729Pkg::ADDR_W-1:0] hostAddr,
	input logic hostWrite,
	input g729Pkg::memWord_t hostWriteData,
	output g729Pkg::memWord_t hostReadData
);
	import g729Pkg::*;

	// Memory side of convolve
	logic [ADDR_W-1:0] convAddr;
	logic convWrite;
	memWord_t convWriteData;

	// Shared memory port after the mux
	logic [ADDR_W-1:0] memAddr;
	logic memWrite;
	memWord_t memWriteData;
	memWord_t memReadData;

	// MAC operands and result
	word16_t macA;
	word16_t macB;
	word32_t macAcc;
	word32_t macSum;

	////////////////////////////////////////////////////////////
	// Memory port mux
	////////////////////////////////////////////////////////////

	// Convolve owns the memory while busy
	// Host writes during busy are lost
	always_comb
	begin
		if (busy)
		begin
			memAddr = convAddr;
			memWrite = convWrite;
			memWriteData = convWriteData;
		end
		else
		begin
			memAddr = hostAddr;
			memWrite = hostWrite;
			memWriteData = hostWriteData;
		end
	end

	// Same read latency on both sides
	assign hostReadData = memReadData;

	////////////////////////////////////////////////////////////
	// Instances
	////////////////////////////////////////////////////////////

	convolve convolve_i
	(
		.clk(clk),
		.reset(reset),
		.start(start),
		.busy(busy),
		.done(done),
		.memAddr(convAddr),
		.memWrite(convWrite),
		.memWriteData(convWriteData),
		.memReadData(memReadData),
		.macA(macA),
		.macB(macB),
		.macAcc(macAcc),
		.macSum(macSum)
	);

	lMac lMac_i
	(
		.a(macA),
		.b(macB),
		.acc(macAcc),
		.sum(macSum)
	);

	scratchMem scratchMem_i
	(
		.clk(clk),
		.addr(memAddr),
		.write(memWrite),
		.writeData(memWriteData),
		.readData(memReadData)
	);

endmodule

/* verilog/convolve.sv */
module convolve
(
	input logic clk,
	input logic reset,
	input logic start,
	output logic busy,
	output logic done,
	output logic [g729Pkg::ADDR_W-1:0] memAddr,
	output logic memWrite,
	output g729Pkg::memWord_t memWriteData,
	input g729Pkg::memWord_t memReadData,
	output g729Pkg::word16_t macA,
	output g729Pkg::word16_t macB,
	output g729Pkg::word32_t macAcc,
	input g729Pkg::word32_t macSum
);
	import g729Pkg::*;

	// FSM encoding
	localparam logic [2:0] STATE_IDLE = 3'd0;
	localparam logic [2:0] STATE_LOOP = 3'd1;
	localparam logic [2:0] STATE_FETCH = 3'd2;
	localparam logic [2:0] STATE_ACCUMULATE = 3'd3;
	localparam logic [2:0] STATE_STORE = 3'd4;

	logic [2:0] state;
	logic [2:0] nextState;

	// Outer counter, output index
	logic [$clog2(L_SUB)-1:0] n;
	// Inner counter, product index
	logic [$clog2(L_SUB)-1:0] i;
	// Step within one fetch
	logic [1:0] phase;

	// Counter strobes from the FSM
	logic nReset;
	logic nInc;
	logic iReset;
	logic iInc;
	logic phaseReset;
	logic phaseInc;

	// Datapath strobes
	logic captureX;
	logic captureH;
	logic accClear;
	logic accLoad;
	logic launch;
	logic finish;

	// Operand registers and running sum
	word16_t xSample;
	word16_t hSample;
	word32_t acc;

	////////////////////////////////////////////////////////////
	// State and counter flops
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= STATE_IDLE;
		else
			state <= nextState;
	end

	always_ff @(posedge clk)
	begin
		if (reset || nReset)
			n <= '0;
		else if (nInc)
			n <= n + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (reset || iReset)
			i <= '0;
		else if (iInc)
			i <= i + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (reset || phaseReset)
			phase <= '0;
		else if (phaseInc)
			phase <= phase + 1'b1;
	end

	////////////////////////////////////////////////////////////
	// Next state, memory port and strobes
	////////////////////////////////////////////////////////////

	always_comb
	begin
		nextState = state;
		nReset = 1'b0;
		nInc = 1'b0;
		iReset = 1'b0;
		iInc = 1'b0;
		phaseReset = 1'b0;
		phaseInc = 1'b0;
		captureX = 1'b0;
		captureH = 1'b0;
		accClear = 1'b0;
		accLoad = 1'b0;
		launch = 1'b0;
		finish = 1'b0;
		memAddr = '0;
		memWrite = 1'b0;
		memWriteData = '0;

		case (state)
			STATE_IDLE:
			begin
				// Hold n at zero until started
				nReset = 1'b1;
				if (start)
				begin
					launch = 1'b1;
					nextState = STATE_LOOP;
				end
			end

			STATE_LOOP:
			begin
				// New output, restart inner loop from i = 0
				iReset = 1'b1;
				phaseReset = 1'b1;
				accClear = 1'b1;
				nextState = STATE_FETCH;
			end

			STATE_FETCH:
			begin
				case (phase)
					2'd0:
					begin
						// x[i] address
						memAddr = X_BASE + ADDR_W'(i);
						phaseInc = 1'b1;
					end
					2'd1:
					begin
						// h[n-i] address, x word on the read port
						memAddr = H_BASE + ADDR_W'(n) - ADDR_W'(i);
						captureX = 1'b1;
						phaseInc = 1'b1;
					end
					default:
					begin
						// h word on the read port
						captureH = 1'b1;
						phaseReset = 1'b1;
						nextState = STATE_ACCUMULATE;
					end
				endcase
			end

			STATE_ACCUMULATE:
			begin
				accLoad = 1'b1;
				// Last product of this output when i reaches n
				if (i == n)
				begin
					nextState = STATE_STORE;
				end
				else
				begin
					iInc = 1'b1;
					nextState = STATE_FETCH;
				end
			end

			STATE_STORE:
			begin
				memAddr = Y_BASE + ADDR_W'(n);
				memWrite = 1'b1;
				memWriteData.full = acc;
				if (n == L_SUB - 1)
				begin
					finish = 1'b1;
					nextState = STATE_IDLE;
				end
				else
				begin
					nInc = 1'b1;
					nextState = STATE_LOOP;
				end
			end

			default:
			begin
				nextState = STATE_IDLE;
			end
		endcase
	end

	////////////////////////////////////////////////////////////
	// Operands and accumulator
	////////////////////////////////////////////////////////////

	// Samples come from the low half
	always_ff @(posedge clk)
	begin
		if (captureX)
			xSample <= memReadData.half.lo;
		if (captureH)
			hSample <= memReadData.half.lo;
	end

	always_ff @(posedge clk)
	begin
		if (reset || accClear)
			acc <= '0;
		else if (accLoad)
			acc <= macSum;
	end

	// MAC operands straight from the registers
	assign macA = xSample;
	assign macB = hSample;
	assign macAcc = acc;

	////////////////////////////////////////////////////////////
	// Busy level and done pulse
	////////////////////////////////////////////////////////////

	// Done follows the last write, busy drops with it
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			done <= finish;
			if (launch)
				busy <= 1'b1;
			else if (finish)
				busy <= 1'b0;
		end
	end

endmodule

/* verilog/lMac.sv */
module lMac
(
	input g729Pkg::word16_t a,
	input g729Pkg::word16_t b,
	input g729Pkg::word32_t acc,
	output g729Pkg::word32_t sum
);
	import g729Pkg::*;

	// Plain 16x16 product
	word32_t rawProduct;
	// L_mult result
	word32_t product;
	// Sign-extended sum, one guard bit
	logic [32:0] wideSum;

	////////////////////////////////////////////////////////////
	// L_mult
	////////////////////////////////////////////////////////////

	always_comb
	begin
		// Both operands signed, full 32-bit context
		rawProduct = a * b;

		// Only -32768 * -32768 overflows when doubled
		if (a == 16'sh8000 && b == 16'sh8000)
		begin
			product = MAX_32;
		end
		else
		begin
			product = {rawProduct[30:0], 1'b0};
		end
	end

	////////////////////////////////////////////////////////////
	// L_add
	////////////////////////////////////////////////////////////

	always_comb
	begin
		wideSum = {acc[31], acc} + {product[31], product};

		// Guard bit disagrees with sign bit on overflow
		if (wideSum[32] != wideSum[31])
		begin
			// Guard bit holds the true sign
			sum = wideSum[32] ? MIN_32 : MAX_32;
		end
		else
		begin
			sum = wideSum[31:0];
		end
	end

endmodule

/* verilog/scratchMem.sv */
module scratchMem
(
	input logic clk,
	input logic [g729Pkg::ADDR_W-1:0] addr,
	input logic write,
	input g729Pkg::memWord_t writeData,
	output g729Pkg::memWord_t readData
);
	import g729Pkg::*;

	// Storage for x, h and y regions
	memWord_t mem [0:(1 << ADDR_W)-1];

	////////////////////////////////////////////////////////////
	// Write port
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (write)
		begin
			mem[addr] <= writeData;
		end
	end

	////////////////////////////////////////////////////////////
	// Read port
	////////////////////////////////////////////////////////////

	// One cycle latency
	// Read during write returns the old word
	always_ff @(posedge clk)
	begin
		readData <= mem[addr];
	end

endmodule

/* verilog/g729Pkg.sv */
package g729Pkg;

	////////////////////////////////////////////////////////////
	// Fixed-point formats
	////////////////////////////////////////////////////////////

	// Speech sample or filter coefficient, Q15
	typedef logic signed [15:0] word16_t;

	// Accumulator value
	typedef logic signed [31:0] word32_t;

	// Scratch memory word
	// Samples sit in the low half, sums fill the whole word
	typedef union packed
	{
		word32_t full;
		struct packed
		{
			word16_t hi;
			word16_t lo;
		} half;
	} memWord_t;

	////////////////////////////////////////////////////////////
	// Memory map and vector length
	////////////////////////////////////////////////////////////

	// 2048-word scratch space
	localparam int ADDR_W = 11;

	// Subframe length
	localparam int L_SUB = 40;

	// Region bases, word addresses
	localparam logic [ADDR_W-1:0] X_BASE = 11'd0;
	localparam logic [ADDR_W-1:0] H_BASE = 11'd64;
	localparam logic [ADDR_W-1:0] Y_BASE = 11'd128;

	// Saturation limits of the 32-bit operators
	localparam word32_t MAX_32 = 32'sh7fff_ffff;
	localparam word32_t MIN_32 = 32'sh8000_0000;

endpackage
